//--- Bender.yml
package:
  name: qu_front_end

sources:
  - source/qu_pkg.sv
  - source/qu_fifo.sv
  - source/qu_fetch.sv
  - source/qu_decode.sv
  - source/qu_map.sv
  - source/qu_busy_table.sv
  - source/qu_dispatch.sv
  - source/qu_front_end.sv
  - target: test
    files:
      - testbench/tb_qu_front_end.sv

//--- source/qu_busy_table.sv
/*
 Busy table
 - one busy bit per physical register
 - two combinational read ports
 - set and clear ports with priority on set
*/
module qu_busy_table #(
    parameter int num_pregs = 48,
    parameter type preg_t = logic [$clog2(num_pregs)-1:0]
) (
    input  logic  clk,
    input  logic  rst_n,
    input  preg_t rd1_preg,
    input  preg_t rd2_preg,
    output logic  busy1,
    output logic  busy2,
    input  logic  set_en,
    input  preg_t set_preg,
    input  logic  clr_en,
    input  preg_t clr_preg
);

    logic [num_pregs-1:0] busy;

    assign busy1 = busy[rd1_preg];
    assign busy2 = busy[rd2_preg];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (clr_en) begin
                busy[clr_preg] <= 1'b0;
            end
            // Preg 0 stands for x0 and stays ready
            if (set_en && set_preg != '0) begin
                busy[set_preg] <= 1'b1;
            end
        end
    end

endmodule

//--- source/qu_decode.sv
/*
 Combinational decoder
 - OP, OP-IMM and LUI into decoded operations
 - I- and U-immediates
 - nop and invalid encodings flagged as not proper
*/
module qu_decode (
    input  qu_pkg::fetch_pkt_t pkt,
    output qu_pkg::dec_op_t    op,
    output logic               proper
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       base;
    logic       alt;
    logic       known;

    function automatic qu_pkg::alu_op_t alu_of(input logic [2:0] f3, input logic sel_alt);
        qu_pkg::alu_op_t res;
        case (f3)
            3'b000: res = sel_alt ? qu_pkg::alu_sub : qu_pkg::alu_add;
            3'b001: res = qu_pkg::alu_sll;
            3'b010: res = qu_pkg::alu_slt;
            3'b011: res = qu_pkg::alu_sltu;
            3'b100: res = qu_pkg::alu_xor;
            3'b101: res = sel_alt ? qu_pkg::alu_sra : qu_pkg::alu_srl;
            3'b110: res = qu_pkg::alu_or;
            default: res = qu_pkg::alu_and;
        endcase
        return res;
    endfunction

    assign opcode = pkt.instr[6:0];
    assign funct3 = pkt.instr[14:12];
    assign funct7 = pkt.instr[31:25];
    assign base = (funct7 == qu_pkg::funct7_base);
    assign alt = (funct7 == qu_pkg::funct7_alt);

    always_comb begin
        op.pc = pkt.pc;
        op.alu_op = qu_pkg::alu_add;
        op.rd = pkt.instr[11:7];
        op.rs1 = pkt.instr[19:15];
        op.rs2 = pkt.instr[24:20];
        op.use_imm = 1'b0;
        op.imm = {{20{pkt.instr[31]}}, pkt.instr[31:20]};
        known = 1'b0;
        case (opcode)
            qu_pkg::opc_op: begin
                known = base || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
                op.alu_op = alu_of(funct3, alt);
            end
            qu_pkg::opc_op_imm: begin
                // Only shifts look at funct7, and only srai takes the alternate form
                if (funct3 == 3'b001) begin
                    known = base;
                end else if (funct3 == 3'b101) begin
                    known = base || alt;
                end else begin
                    known = 1'b1;
                end
                op.alu_op = alu_of(funct3, alt && funct3 == 3'b101);
                op.rs2 = '0;
                op.use_imm = 1'b1;
            end
            qu_pkg::opc_lui: begin
                known = 1'b1;
                op.alu_op = qu_pkg::alu_lui;
                op.rs1 = '0;
                op.rs2 = '0;
                op.use_imm = 1'b1;
                op.imm = {pkt.instr[31:12], 12'b0};
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    // Writes to x0 are nops
    assign proper = known && (op.rd != '0);

endmodule

//--- source/qu_dispatch.sv
/*
 Dispatch stage
 - credit counter toward the reservation station
 - operand readiness with writeback bypass
 - operand read from the register file
 - registered reservation entry
*/
module qu_dispatch #(
    parameter int rs_credits = 6,
    parameter type preg_t = logic [5:0],
    parameter type ren_op_t = logic,
    parameter type rs_entry_t = logic
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  ren_op_t                    in_op,
    output logic                       drain,
    input  logic                       busy1,
    input  logic                       busy2,
    output preg_t                      rd1_preg,
    output preg_t                      rd2_preg,
    input  logic [qu_pkg::instr_w-1:0] rf_rd1_data,
    input  logic [qu_pkg::instr_w-1:0] rf_rd2_data,
    input  logic                       wb_valid,
    input  preg_t                      wb_preg,
    input  logic                       rs_credit,
    output logic                       rs_valid,
    output rs_entry_t                  rs_entry
);

    localparam int cnt_w = $clog2(rs_credits + 1);

    logic [cnt_w-1:0] credits;
    logic rs1_ready;
    logic rs2_ready;
    rs_entry_t entry;

    assign rd1_preg = in_op.rs1_preg;
    assign rd2_preg = in_op.rs2_preg;
    assign drain = in_valid && (credits != '0);

    // Writeback in this cycle counts as ready
    assign rs1_ready = !busy1 || (wb_valid && wb_preg == in_op.rs1_preg);
    assign rs2_ready = !busy2 || (wb_valid && wb_preg == in_op.rs2_preg);

    always_comb begin
        entry.ren = in_op;
        entry.rs1_ready = rs1_ready;
        entry.rs1_value = rs1_ready ? rf_rd1_data : '0;
        entry.rs2_ready = rs2_ready;
        entry.rs2_value = rs2_ready ? rf_rd2_data : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= cnt_w'(rs_credits);
            rs_valid <= 1'b0;
        end else begin
            credits <= credits - cnt_w'(drain) + cnt_w'(rs_credit);
            rs_valid <= drain;
        end
    end

    always_ff @(posedge clk) begin
        if (drain) begin
            rs_entry <= entry;
        end
    end

endmodule

//--- source/qu_fetch.sv
/*
 Fetch unit
 - program counter and program memory address
 - redirect to a new pc
 - push of fetch packets into the fetch to decode FIFO
*/
module qu_fetch #(
    parameter logic [qu_pkg::pc_w-1:0] reset_pc = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       redirect,
    input  logic [qu_pkg::pc_w-1:0]    redirect_pc,
    output logic [qu_pkg::pc_w-1:0]    imem_addr,
    input  logic [qu_pkg::instr_w-1:0] imem_data,
    input  logic                       fifo_full,
    output logic                       push,
    output qu_pkg::fetch_pkt_t         pkt
);

    logic [qu_pkg::pc_w-1:0] pc;

    // Memory answers in the same cycle
    assign imem_addr = pc;
    assign push = !fifo_full && !redirect;
    assign pkt.pc = pc;
    assign pkt.instr = imem_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (push) begin
            pc <= pc + qu_pkg::pc_w'(4);
        end
    end

endmodule

//--- source/qu_fifo.sv
/*
 Synchronous FIFO
 - circular buffer with read and write pointers and a count
 - payload given as a type parameter
 - flush empties the buffer in one cycle
*/
module qu_fifo #(
    parameter type payload_t = logic,
    parameter int depth = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t wr_data,
    input  logic     pop,
    output payload_t rd_data,
    input  logic     flush,
    output logic     empty,
    output logic     full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    assign rd_data = mem[rd_ptr];
    assign empty = (count == '0);
    assign full = (count == cnt_w'(depth));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

endmodule

//--- source/qu_front_end.sv
/*
 Top level of the in-order front end
 - renamed operation and reservation entry types
 - fetch, two FIFOs, decode, map, busy table and dispatch
 - pop and push gating between the stages
*/
module qu_front_end #(
    parameter int num_pregs = 48,
    parameter int if_id_depth = 4,
    parameter int id_map_depth = 4,
    parameter int rs_credits = 6,
    parameter logic [qu_pkg::pc_w-1:0] reset_pc = '0,
    localparam int preg_w = $clog2(num_pregs),
    localparam type preg_t = logic [preg_w-1:0],
    localparam type ren_op_t = struct packed {
        qu_pkg::dec_op_t op;
        preg_t           rd_preg;
        preg_t           old_rd_preg;
        preg_t           rs1_preg;
        preg_t           rs2_preg;
    },
    localparam type rs_entry_t = struct packed {
        ren_op_t                    ren;
        logic                       rs1_ready;
        logic [qu_pkg::instr_w-1:0] rs1_value;
        logic                       rs2_ready;
        logic [qu_pkg::instr_w-1:0] rs2_value;
    }
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       redirect,
    input  logic [qu_pkg::pc_w-1:0]    redirect_pc,
    output logic [qu_pkg::pc_w-1:0]    imem_addr,
    input  logic [qu_pkg::instr_w-1:0] imem_data,
    output preg_t                      rf_rd1_addr,
    output preg_t                      rf_rd2_addr,
    input  logic [qu_pkg::instr_w-1:0] rf_rd1_data,
    input  logic [qu_pkg::instr_w-1:0] rf_rd2_data,
    input  logic                       wb_valid,
    input  preg_t                      wb_preg,
    input  logic                       free_valid,
    input  preg_t                      free_preg,
    input  logic                       rs_credit,
    output logic                       rs_valid,
    output rs_entry_t                  rs_entry
);

    qu_pkg::fetch_pkt_t fetch_pkt;
    qu_pkg::fetch_pkt_t if_head;
    qu_pkg::dec_op_t dec_op;
    qu_pkg::dec_op_t id_head;
    ren_op_t map_op;
    preg_t busy_set_preg;
    logic fetch_push;
    logic if_pop;
    logic if_empty;
    logic if_full;
    logic dec_proper;
    logic id_push;
    logic id_empty;
    logic id_full;
    logic map_take;
    logic map_valid;
    logic busy_set;
    logic disp_drain;
    logic busy1;
    logic busy2;

    // Drop improper heads even when the next FIFO is full
    assign if_pop = !if_empty && (!id_full || !dec_proper);
    assign id_push = !if_empty && !id_full && dec_proper;

    qu_fetch #(
        .reset_pc(reset_pc)
    ) fetch_inst (
        .clk(clk),
        .rst_n(rst_n),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .fifo_full(if_full),
        .push(fetch_push),
        .pkt(fetch_pkt)
    );

    qu_fifo #(
        .payload_t(qu_pkg::fetch_pkt_t),
        .depth(if_id_depth)
    ) if_id_fifo_inst (
        .clk(clk),
        .rst_n(rst_n),
        .push(fetch_push),
        .wr_data(fetch_pkt),
        .pop(if_pop),
        .rd_data(if_head),
        .flush(redirect),
        .empty(if_empty),
        .full(if_full)
    );

    qu_decode decode_inst (
        .pkt(if_head),
        .op(dec_op),
        .proper(dec_proper)
    );

    qu_fifo #(
        .payload_t(qu_pkg::dec_op_t),
        .depth(id_map_depth)
    ) id_map_fifo_inst (
        .clk(clk),
        .rst_n(rst_n),
        .push(id_push),
        .wr_data(dec_op),
        .pop(map_take),
        .rd_data(id_head),
        .flush(1'b0),
        .empty(id_empty),
        .full(id_full)
    );

    qu_map #(
        .num_pregs(num_pregs),
        .preg_t(preg_t),
        .ren_op_t(ren_op_t)
    ) map_inst (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(!id_empty),
        .in_op(id_head),
        .take(map_take),
        .free_valid(free_valid),
        .free_preg(free_preg),
        .busy_set(busy_set),
        .busy_set_preg(busy_set_preg),
        .out_valid(map_valid),
        .out_op(map_op),
        .drain(disp_drain)
    );

    qu_busy_table #(
        .num_pregs(num_pregs),
        .preg_t(preg_t)
    ) busy_table_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rd1_preg(rf_rd1_addr),
        .rd2_preg(rf_rd2_addr),
        .busy1(busy1),
        .busy2(busy2),
        .set_en(busy_set),
        .set_preg(busy_set_preg),
        .clr_en(wb_valid),
        .clr_preg(wb_preg)
    );

    qu_dispatch #(
        .rs_credits(rs_credits),
        .preg_t(preg_t),
        .ren_op_t(ren_op_t),
        .rs_entry_t(rs_entry_t)
    ) dispatch_inst (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(map_valid),
        .in_op(map_op),
        .drain(disp_drain),
        .busy1(busy1),
        .busy2(busy2),
        .rd1_preg(rf_rd1_addr),
        .rd2_preg(rf_rd2_addr),
        .rf_rd1_data(rf_rd1_data),
        .rf_rd2_data(rf_rd2_data),
        .wb_valid(wb_valid),
        .wb_preg(wb_preg),
        .rs_credit(rs_credit),
        .rs_valid(rs_valid),
        .rs_entry(rs_entry)
    );

endmodule

//--- source/qu_map.sv
/*
 Map stage
 - register alias table
 - free-list bitmap with lowest-free allocation
 - busy-set write for each new destination
 - output register holding one renamed operation
*/
module qu_map #(
    parameter int num_pregs = 48,
    parameter type preg_t = logic [$clog2(num_pregs)-1:0],
    parameter type ren_op_t = logic
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  qu_pkg::dec_op_t in_op,
    output logic            take,
    input  logic            free_valid,
    input  preg_t           free_preg,
    output logic            busy_set,
    output preg_t           busy_set_preg,
    output logic            out_valid,
    output ren_op_t         out_op,
    input  logic            drain
);

    preg_t rat [qu_pkg::arch_regs];
    logic [num_pregs-1:0] free_map;
    preg_t alloc_preg;
    logic any_free;

    // Lowest free register wins
    always_comb begin
        alloc_preg = '0;
        for (int i = num_pregs - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_preg = preg_t'(i);
            end
        end
    end

    assign any_free = |free_map;
    assign take = in_valid && any_free && (!out_valid || drain);
    assign busy_set = take;
    assign busy_set_preg = alloc_preg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < qu_pkg::arch_regs; i++) begin
                rat[i] <= preg_t'(i);
            end
        end else if (take) begin
            rat[in_op.rd] <= alloc_preg;
        end
    end

    // Allocation and free never hit the same register in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_pregs; i++) begin
                free_map[i] <= (i >= qu_pkg::arch_regs);
            end
        end else begin
            if (take) begin
                free_map[alloc_preg] <= 1'b0;
            end
            if (free_valid) begin
                free_map[free_preg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (drain) begin
            out_valid <= 1'b0;
        end
    end

    // Sources read the table before the rd update lands
    always_ff @(posedge clk) begin
        if (take) begin
            out_op.op <= in_op;
            out_op.rd_preg <= alloc_preg;
            out_op.old_rd_preg <= rat[in_op.rd];
            out_op.rs1_preg <= rat[in_op.rs1];
            out_op.rs2_preg <= rat[in_op.rs2];
        end
    end

endmodule

//--- source/qu_pkg.sv
/*
 Shared definitions of the front end
 - instruction, pc and architectural register widths
 - major opcodes and funct7 values kept by decode
 - alu operation codes
 - fetch packet and decoded operation structs
*/
package qu_pkg;

    localparam int instr_w = 32;
    localparam int pc_w = 32;
    localparam int arch_regs = 32;

    typedef logic [$clog2(arch_regs)-1:0] arch_t;

    // Major opcodes handled by decode
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_lui  = 4'd10
    } alu_op_t;

    typedef struct packed {
        logic [pc_w-1:0]    pc;
        logic [instr_w-1:0] instr;
    } fetch_pkt_t;

    // Decoded operation with rs2 at x0 when an immediate is used
    typedef struct packed {
        logic [pc_w-1:0]    pc;
        alu_op_t            alu_op;
        arch_t              rd;
        arch_t              rs1;
        arch_t              rs2;
        logic               use_imm;
        logic [instr_w-1:0] imm;
    } dec_op_t;

endpackage

//--- src.f
source/qu_pkg.sv
source/qu_fifo.sv
source/qu_fetch.sv
source/qu_decode.sv
source/qu_map.sv
source/qu_busy_table.sv
source/qu_dispatch.sv
source/qu_front_end.sv
testbench/tb_qu_front_end.sv

//--- testbench/tb_qu_front_end.sv
/*
 Testbench of the front end
 - random program memory and register file model
 - reservation station, writeback and free models
 - renaming reference model and order, operand and credit checks
 - credit hold and free-list pressure phases
*/
module tb_qu_front_end;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_pregs = 48;
    localparam int preg_w = $clog2(num_pregs);
    localparam int rs_credits = 6;
    localparam int run_entries = 300;
    localparam int timeout_cycles = 20 * run_entries;
    localparam int not_issued = -1;

    typedef logic [preg_w-1:0] preg_t;

    typedef struct packed {
        qu_pkg::dec_op_t op;
        preg_t           rd_preg;
        preg_t           old_rd_preg;
        preg_t           rs1_preg;
        preg_t           rs2_preg;
    } ren_op_t;

    typedef struct packed {
        ren_op_t     ren;
        logic        rs1_ready;
        logic [31:0] rs1_value;
        logic        rs2_ready;
        logic [31:0] rs2_value;
    } rs_entry_t;

    typedef struct packed {
        logic            proper;
        qu_pkg::dec_op_t op;
    } model_op_t;

    logic clk = 1'b0;
    logic rst_n;
    logic redirect;
    logic [31:0] redirect_pc;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    preg_t rf_rd1_addr;
    preg_t rf_rd2_addr;
    logic [31:0] rf_rd1_data;
    logic [31:0] rf_rd2_data;
    logic wb_valid;
    preg_t wb_preg;
    logic free_valid;
    preg_t free_preg;
    logic rs_credit;
    logic rs_valid;
    rs_entry_t rs_entry;

    logic [31:0] prog [256];
    preg_t m_rat [32];
    bit live [num_pregs];
    int wb_cycle [num_pregs];
    logic [31:0] redirect_q [$];
    int credit_due [$];
    int wb_due [$];
    preg_t wb_rd [$];
    preg_t wb_old [$];
    int free_due [$];
    preg_t free_q [$];
    int redirect_at [2] = '{60, 160};
    int redirects_done = 0;
    int cycle = 0;
    int received = 0;
    int outstanding = 0;
    int last_credit_due = 0;
    int last_wb_due = 0;
    logic [31:0] seq_from = 32'h0;
    int credit_mode = 0;
    int zero_cycles = 0;
    int free_mode = 0;
    int free_cycles = 0;
    int free_at_start = 0;
    int hold_received = 0;

    always #50 clk = ~clk;

    assign imem_data = prog[imem_addr[9:2]];
    assign rf_rd1_data = rf_value(rf_rd1_addr);
    assign rf_rd2_data = rf_value(rf_rd2_addr);

    qu_front_end #(
        .num_pregs(num_pregs),
        .if_id_depth(4),
        .id_map_depth(4),
        .rs_credits(rs_credits),
        .reset_pc(32'h0)
    ) qu_front_end_inst (
        .clk(clk),
        .rst_n(rst_n),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .rf_rd1_addr(rf_rd1_addr),
        .rf_rd2_addr(rf_rd2_addr),
        .rf_rd1_data(rf_rd1_data),
        .rf_rd2_data(rf_rd2_data),
        .wb_valid(wb_valid),
        .wb_preg(wb_preg),
        .free_valid(free_valid),
        .free_preg(free_preg),
        .rs_credit(rs_credit),
        .rs_valid(rs_valid),
        .rs_entry(rs_entry)
    );

    function automatic logic [31:0] rf_value(input preg_t p);
        return 32'(p) * 32'h01010101;
    endfunction

    // Mostly OP, OP-IMM and LUI with stray opcodes and rd x0 mixed in
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        int kind;
        w = $urandom;
        kind = $urandom % 10;
        if (kind >= 1 && kind <= 4) begin
            w[6:0] = 7'h33;
            w[31:25] = ($urandom % 4 == 0) ? 7'h20 : 7'h00;
        end else if (kind >= 5 && kind <= 7) begin
            w[6:0] = 7'h13;
            if (w[13:12] == 2'b01) begin
                w[31:25] = ($urandom % 4 == 0) ? 7'h20 : 7'h00;
            end
        end else if (kind >= 8) begin
            w[6:0] = 7'h37;
        end
        if ($urandom % 8 == 0) begin
            w[11:7] = 5'd0;
        end
        return w;
    endfunction

    function automatic model_op_t model_decode(input logic [31:0] w);
        model_op_t m;
        logic [2:0] f3;
        logic [6:0] f7;
        bit ok;
        f3 = w[14:12];
        f7 = w[31:25];
        ok = 1'b0;
        m = '0;
        m.op.rd = w[11:7];
        m.op.rs1 = w[19:15];
        m.op.rs2 = w[24:20];
        case (f3)
            3'd0: m.op.alu_op = qu_pkg::alu_add;
            3'd1: m.op.alu_op = qu_pkg::alu_sll;
            3'd2: m.op.alu_op = qu_pkg::alu_slt;
            3'd3: m.op.alu_op = qu_pkg::alu_sltu;
            3'd4: m.op.alu_op = qu_pkg::alu_xor;
            3'd5: m.op.alu_op = qu_pkg::alu_srl;
            3'd6: m.op.alu_op = qu_pkg::alu_or;
            default: m.op.alu_op = qu_pkg::alu_and;
        endcase
        if (w[6:0] == 7'h33) begin
            if (f7 == 7'h00) begin
                ok = 1'b1;
            end else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) begin
                ok = 1'b1;
                m.op.alu_op = (f3 == 3'd0) ? qu_pkg::alu_sub : qu_pkg::alu_sra;
            end
        end else if (w[6:0] == 7'h13) begin
            m.op.use_imm = 1'b1;
            m.op.rs2 = '0;
            m.op.imm = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'd1) begin
                ok = (f7 == 7'h00);
            end else if (f3 == 3'd5) begin
                ok = (f7 == 7'h00 || f7 == 7'h20);
                if (f7 == 7'h20) begin
                    m.op.alu_op = qu_pkg::alu_sra;
                end
            end else begin
                ok = 1'b1;
            end
        end else if (w[6:0] == 7'h37) begin
            ok = 1'b1;
            m.op.alu_op = qu_pkg::alu_lui;
            m.op.rs1 = '0;
            m.op.rs2 = '0;
            m.op.use_imm = 1'b1;
            m.op.imm = {w[31:12], 12'h000};
        end
        m.proper = ok && (m.op.rd != 5'd0);
        return m;
    endfunction

    // Next pc at or after from that survives decode
    function automatic logic [31:0] first_proper(input logic [31:0] from);
        logic [31:0] pc;
        model_op_t m;
        pc = from;
        for (int i = 0; i < 256; i++) begin
            m = model_decode(prog[pc[9:2]]);
            if (m.proper) begin
                return pc;
            end
            pc = pc + 32'd4;
        end
        return 32'hffff_ffff;
    endfunction

    function automatic int count_live();
        int n;
        n = 0;
        for (int i = 0; i < num_pregs; i++) begin
            n += live[i];
        end
        return n;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at cycle %0d", cycle);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        assert (got === expected) else begin
            stop_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    task automatic check_source(input string name, input preg_t p, input logic ready,
                                input logic [31:0] value);
        if (ready) begin
            compare_field({name, "_value"}, value, rf_value(p));
        end else begin
            compare_field({name, "_value"}, value, 32'h0);
        end
        if (wb_cycle[p] != not_issued && wb_cycle[p] <= cycle - 2) begin
            assert (ready) else begin
                stop_run($sformatf("%s on preg %0d not ready after its writeback", name, p));
            end
        end
        if (wb_cycle[p] == not_issued) begin
            assert (!ready) else begin
                stop_run($sformatf("%s on preg %0d ready before its writeback", name, p));
            end
        end
    endtask

    task automatic check_entry();
        rs_entry_t e;
        model_op_t m;
        int hit;
        int due;
        e = rs_entry;
        hit = -1;
        foreach (redirect_q[i]) begin
            if (hit < 0 && first_proper(redirect_q[i]) == e.ren.op.pc) begin
                hit = i;
            end
        end
        if (hit >= 0) begin
            repeat (hit + 1) begin
                void'(redirect_q.pop_front());
            end
        end else begin
            compare_field("rs_entry.pc", e.ren.op.pc, first_proper(seq_from));
        end
        seq_from = e.ren.op.pc + 32'd4;
        m = model_decode(prog[e.ren.op.pc[9:2]]);
        compare_field("rs_entry.alu_op", 32'(e.ren.op.alu_op), 32'(m.op.alu_op));
        compare_field("rs_entry.rd", 32'(e.ren.op.rd), 32'(m.op.rd));
        compare_field("rs_entry.rs1", 32'(e.ren.op.rs1), 32'(m.op.rs1));
        compare_field("rs_entry.rs2", 32'(e.ren.op.rs2), 32'(m.op.rs2));
        compare_field("rs_entry.use_imm", 32'(e.ren.op.use_imm), 32'(m.op.use_imm));
        if (m.op.use_imm) begin
            compare_field("rs_entry.imm", e.ren.op.imm, m.op.imm);
        end
        compare_field("rs_entry.rs1_preg", 32'(e.ren.rs1_preg), 32'(m_rat[m.op.rs1]));
        compare_field("rs_entry.rs2_preg", 32'(e.ren.rs2_preg), 32'(m_rat[m.op.rs2]));
        compare_field("rs_entry.old_rd_preg", 32'(e.ren.old_rd_preg), 32'(m_rat[m.op.rd]));
        assert (!live[e.ren.rd_preg]) else begin
            stop_run($sformatf("Destination preg %0d is still live", e.ren.rd_preg));
        end
        check_source("rs_entry.rs1", e.ren.rs1_preg, e.rs1_ready, e.rs1_value);
        check_source("rs_entry.rs2", e.ren.rs2_preg, e.rs2_ready, e.rs2_value);
        m_rat[m.op.rd] = e.ren.rd_preg;
        live[e.ren.rd_preg] = 1'b1;
        wb_cycle[e.ren.rd_preg] = not_issued;
        // Writebacks stay in order so a freed preg has no late writeback
        due = cycle + 1 + int'($urandom % 6);
        last_wb_due = (due > last_wb_due) ? due : last_wb_due + 1;
        wb_due.push_back(last_wb_due);
        wb_rd.push_back(e.ren.rd_preg);
        wb_old.push_back(e.ren.old_rd_preg);
        due = cycle + 1 + int'($urandom % 8);
        last_credit_due = (due > last_credit_due) ? due : last_credit_due + 1;
        credit_due.push_back(last_credit_due);
        outstanding++;
        received++;
        assert (outstanding <= rs_credits) else begin
            stop_run($sformatf("%0d entries outstanding with %0d credits", outstanding, rs_credits));
        end
    endtask

    task automatic drive_inputs();
        redirect = 1'b0;
        wb_valid = 1'b0;
        free_valid = 1'b0;
        rs_credit = 1'b0;
        if (redirects_done < 2 && received >= redirect_at[redirects_done]) begin
            redirect = 1'b1;
            redirect_pc = 32'($urandom % 256) * 32'd4;
            redirect_q.push_back(redirect_pc);
            redirects_done++;
        end
        if ((credit_mode == 0 || credit_mode == 3) && credit_due.size() > 0
                && credit_due[0] <= cycle) begin
            rs_credit = 1'b1;
            void'(credit_due.pop_front());
            outstanding--;
        end
        if (wb_due.size() > 0 && wb_due[0] <= cycle) begin
            wb_valid = 1'b1;
            wb_preg = wb_rd[0];
            wb_cycle[wb_rd[0]] = cycle;
            free_due.push_back(cycle + 1);
            free_q.push_back(wb_old[0]);
            void'(wb_due.pop_front());
            void'(wb_rd.pop_front());
            void'(wb_old.pop_front());
        end
        if (free_mode != 1 && free_due.size() > 0 && free_due[0] <= cycle) begin
            free_valid = 1'b1;
            free_preg = free_q[0];
            live[free_q[0]] = 1'b0;
            void'(free_due.pop_front());
            void'(free_q.pop_front());
        end
    endtask

    task automatic monitor_outputs();
        if (credit_mode == 2) begin
            assert (!rs_valid) else begin
                stop_run("Entry dispatched while all credits were spent");
            end
        end
        if (rs_valid) begin
            check_entry();
        end
        if (free_mode == 0 && received >= 200) begin
            free_mode = 1;
            free_cycles = 0;
            hold_received = 0;
            free_at_start = num_pregs - count_live();
        end else if (free_mode == 1) begin
            free_cycles++;
            hold_received += int'(rs_valid);
            assert (hold_received <= free_at_start) else begin
                stop_run("Dispatch went on past the free list while frees were held");
            end
            if (free_cycles == 60) begin
                free_mode = 2;
            end
        end
        case (credit_mode)
            0: begin
                if (received >= 100) begin
                    credit_mode = 1;
                end
            end
            1: begin
                if (outstanding == rs_credits) begin
                    credit_mode = 2;
                    zero_cycles = 0;
                end
            end
            2: begin
                zero_cycles++;
                if (zero_cycles == 40) begin
                    credit_mode = 3;
                end
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        rst_n = 1'b0;
        redirect = 1'b0;
        redirect_pc = 32'h0;
        wb_valid = 1'b0;
        wb_preg = '0;
        free_valid = 1'b0;
        free_preg = '0;
        rs_credit = 1'b0;
        void'($urandom(32'h133c));
        for (int i = 0; i < 256; i++) begin
            prog[i] = random_word();
        end
        for (int i = 0; i < 32; i++) begin
            m_rat[i] = preg_t'(i);
        end
        for (int i = 0; i < num_pregs; i++) begin
            live[i] = (i < 32);
            wb_cycle[i] = -100;
        end
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        while (received < run_entries) begin
            @(posedge clk);
            cycle++;
            if (cycle > timeout_cycles) begin
                stop_run($sformatf("Timeout after %0d cycles with %0d entries", cycle, received));
            end
            #1;
            drive_inputs();
            @(negedge clk);
            monitor_outputs();
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
